/* rtl/zet_defines.svh */
// shared constants for the execution core
// register indices, reset values, multiplier pacing, write-source codes

`ifndef ZET_DEFINES_SVH
`define ZET_DEFINES_SVH

// ========================================
// register file indices
// ========================================
`define ZET_REG_AX 4'd0
`define ZET_REG_CX 4'd1
`define ZET_REG_DX 4'd2
`define ZET_REG_CS 4'd9
`define ZET_REG_IP 4'd15

// x86 reset vector f000:fff0
`define ZET_CS_RESET 16'hf000
`define ZET_IP_RESET 16'hfff0

// one multiplier step per multiplier bit
`define ZET_MUL_STEPS 5'd16

// write-data source select
`define ZET_DSEL_ALU 2'd0
`define ZET_DSEL_MUL 2'd1
`define ZET_DSEL_CX  2'd2
`define ZET_DSEL_IP  2'd3

`endif

/* rtl/zet_pkg.sv */
// micro-op opcode enum, micro-op struct, flags struct

package zet_pkg;

  // ========================================
  // micro-op encoding
  // ========================================
  typedef enum logic [3:0] {
    MOV_IMM = 4'd0,
    ADD     = 4'd1,
    SUB     = 4'd2,
    AND     = 4'd3,
    OR      = 4'd4,
    XOR     = 4'd5,
    MUL     = 4'd6,
    LOOP    = 4'd7
  } uop_opcode_e;

  // one issued micro-op
  // dst/src use the register file encoding, 0-7 are AL..BH when byte wide
  typedef struct packed {
    uop_opcode_e opcode;
    logic [3:0]  dst;
    logic [3:0]  src;
    logic        use_imm;
    logic [15:0] imm;
    logic        word_op;
  } uop_t;

  // ========================================
  // flags, same bit order as the register file
  // ========================================
  typedef struct packed {
    logic of;
    logic df;
    logic if_f;
    logic tf;
    logic sf;
    logic zf;
    logic af;
    logic pf;
    logic cf;
  } flags_t;

endpackage

/* rtl/zet_regfile.sv */
// x86 register file: sixteen words with byte and word access
// plus flags register, IP, CS and the CX-zero detect

`timescale 1ns/10ps

`include "zet_defines.svh"

module zet_regfile import zet_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  output logic [15:0] a,
  output logic [15:0] b,
  output logic [15:0] c,
  output logic [15:0] cs,
  output logic [15:0] ip,
  output logic [15:0] s,
  input  logic [31:0] d,
  output flags_t      flags,
  input  logic        wr,
  input  logic        wrfl,
  input  logic        wrhi,
  input  logic        word_op,
  input  logic        a_byte,
  input  logic        b_byte,
  input  logic        c_byte,
  input  logic        wr_ip0,
  input  flags_t      iflags,
  input  logic [3:0]  addr_a,
  input  logic [3:0]  addr_b,
  input  logic [3:0]  addr_c,
  input  logic [3:0]  addr_d,
  input  logic [1:0]  addr_s,
  output logic        cx_zero
);

  logic [15:0] r [16];

  // byte view of a word register, bit 2 picks the high half (AH..BH)
  function automatic logic [15:0] rd_port(input logic [3:0] addr, input logic byte_rd);
    logic [7:0] half;
    half = addr[2] ? r[{2'b00, addr[1:0]}][15:8] : r[addr][7:0];
    // segment and upper registers are always read as words
    if (byte_rd && !addr[3]) begin
      return {{8{half[7]}}, half};
    end
    return r[addr];
  endfunction

  assign a  = rd_port(addr_a, a_byte);
  assign b  = rd_port(addr_b, b_byte);
  assign c  = rd_port(addr_c, c_byte);
  assign s  = r[{2'b10, addr_s}];
  assign cs = r[`ZET_REG_CS];
  assign ip = r[`ZET_REG_IP];

  // a CX write in flight is looked through so LOOP sees the new count
  assign cx_zero = (wr && word_op && addr_d == `ZET_REG_CX) ? (d[15:0] == 16'd0)
                                                            : (r[`ZET_REG_CX] == 16'd0);

  // ========================================
  // write side
  // ========================================
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 16; i++) begin
        r[i] <= 16'd0;
      end
      r[`ZET_REG_CS] <= `ZET_CS_RESET;
      r[`ZET_REG_IP] <= `ZET_IP_RESET;
      flags          <= '0;
    end else begin
      if (wr) begin
        if (word_op || addr_d[3:2] == 2'b10) begin
          // segments take a sign extended byte on a byte write
          r[addr_d] <= word_op ? d[15:0] : {{8{d[7]}}, d[7:0]};
        end else if (addr_d[3] == addr_d[2]) begin
          r[addr_d][7:0] <= d[7:0];
        end else begin
          // AH, CH, DH, BH
          r[{2'b00, addr_d[1:0]}][15:8] <= d[7:0];
        end
      end
      if (wrfl) begin
        flags <= iflags;
      end
      // upper product word goes to DX
      if (wrhi) begin
        r[`ZET_REG_DX] <= d[31:16];
      end
      if (wr_ip0) begin
        r[14] <= r[`ZET_REG_IP];
      end
    end
  end

endmodule

/* rtl/zet_alu.sv */
// combinational ALU for MOV, ADD, SUB, AND, OR, XOR
// x86 flag generation at byte or word width

`timescale 1ns/10ps

module zet_alu import zet_pkg::*; (
  input  uop_opcode_e op,
  input  logic [15:0] x,
  input  logic [15:0] y,
  input  logic        word_op,
  input  flags_t      fin,
  output logic [15:0] res,
  output flags_t      fout
);

  logic [16:0] sum_w;
  logic [16:0] dif_w;
  logic [8:0]  sum_b;
  logic [8:0]  dif_b;
  logic [15:0] r;
  logic        carry;
  logic        msb_x;
  logic        msb_y;
  logic        msb_r;
  logic        arith;

  // both widths are computed, word_op picks the carry out
  assign sum_w = {1'b0, x} + {1'b0, y};
  assign dif_w = {1'b0, x} - {1'b0, y};
  assign sum_b = {1'b0, x[7:0]} + {1'b0, y[7:0]};
  assign dif_b = {1'b0, x[7:0]} - {1'b0, y[7:0]};

  always_comb begin
    carry = 1'b0;
    arith = 1'b0;
    unique case (op)
      ADD: begin
        r     = sum_w[15:0];
        carry = word_op ? sum_w[16] : sum_b[8];
        arith = 1'b1;
      end
      SUB: begin
        r     = dif_w[15:0];
        // borrow out
        carry = word_op ? dif_w[16] : dif_b[8];
        arith = 1'b1;
      end
      AND:     r = x & y;
      OR:      r = x | y;
      XOR:     r = x ^ y;
      default: r = y;
    endcase
  end

  // byte results are sign extended like a byte register read
  assign res = word_op ? r : {{8{r[7]}}, r[7:0]};

  assign msb_x = word_op ? x[15] : x[7];
  assign msb_y = word_op ? y[15] : y[7];
  assign msb_r = word_op ? r[15] : r[7];

  always_comb begin
    // TF, IF, DF and anything not listed pass through
    fout    = fin;
    fout.sf = msb_r;
    fout.zf = word_op ? (r == 16'd0) : (r[7:0] == 8'd0);
    // PF is even parity of the low byte only
    fout.pf = ~^r[7:0];
    fout.cf = carry;
    fout.af = arith & (x[4] ^ y[4] ^ r[4]);
    if (op == ADD) begin
      fout.of = (msb_x == msb_y) && (msb_r != msb_x);
    end else if (op == SUB) begin
      fout.of = (msb_x != msb_y) && (msb_r != msb_x);
    end else begin
      fout.of = 1'b0;
    end
  end

endmodule

/* rtl/zet_mul.sv */
// unsigned 16x16 shift-add multiplier, one bit per step

`timescale 1ns/10ps

module zet_mul import zet_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        start,
  input  logic        step,
  input  logic [15:0] mcand,
  input  logic [15:0] mplier,
  output logic [31:0] product
);

  logic [15:0] mcand_q;
  logic [31:0] prod_q;
  logic [16:0] acc;
  logic [31:0] prod_next;

  // add multiplicand into the top half when the low bit is set,
  // the carry becomes bit 31 after the shift
  assign acc       = {1'b0, prod_q[31:16]} + (prod_q[0] ? {1'b0, mcand_q} : 17'd0);
  assign prod_next = {acc, prod_q[15:1]};

  always_ff @(posedge clk) begin
    if (start) begin
      mcand_q <= mcand;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      prod_q <= '0;
    end else if (start) begin
      // multiplier sits in the low half and is shifted out
      prod_q <= {16'd0, mplier};
    end else if (step) begin
      prod_q <= prod_next;
    end
  end

  // during a step the result of that step is visible,
  // so the final step can be written back on its own edge
  assign product = step ? prod_next : prod_q;

endmodule

/* rtl/zet_step_timer.sv */
// down-counter pacing the multiplier steps

`timescale 1ns/10ps

`include "zet_defines.svh"

module zet_step_timer (
  input  logic clk,
  input  logic rst,
  input  logic start,
  output logic step,
  output logic last
);

  logic [4:0] count;

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else if (start) begin
      count <= `ZET_MUL_STEPS;
    end else if (count != 5'd0) begin
      count <= count - 5'd1;
    end
  end

  assign step = (count != 5'd0);
  assign last = (count == 5'd1);

endmodule

/* rtl/zet_exec_fsm.sv */
// micro-op sequencer: issue latch, state machine and write strobes

`timescale 1ns/10ps

`include "zet_defines.svh"

module zet_exec_fsm import zet_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       issue,
  input  uop_t       uop,
  input  logic       last,
  input  logic       cx_zero,
  output logic       busy,
  output logic       done,
  output uop_t       cur,
  output logic       mul_start,
  output logic       wr,
  output logic       wrfl,
  output logic       wrhi,
  output logic       word_op,
  output logic [1:0] dsel
);

  typedef enum logic [2:0] {
    IDLE,
    ALU,
    MUL_RUN,
    LOOP_DEC,
    LOOP_JMP,
    DONE
  } state_e;

  state_e state;
  state_e state_next;
  logic   accept;
  logic   cx_zero_q;

  // issue only counts while idle, no back-pressure
  assign accept = (state == IDLE) && issue;

  always_ff @(posedge clk) begin
    if (accept) begin
      cur <= uop;
    end
  end

  // ========================================
  // state and control registers
  // ========================================
  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= IDLE;
      mul_start <= 1'b0;
      cx_zero_q <= 1'b0;
    end else begin
      state     <= state_next;
      // timer and multiplier load one cycle after issue
      mul_start <= accept && (uop.opcode == MUL);
      // count seen after the decrement decides the jump
      if (state == LOOP_DEC) begin
        cx_zero_q <= cx_zero;
      end
    end
  end

  always_comb begin
    state_next = state;
    unique case (state)
      IDLE: begin
        if (issue) begin
          if (uop.opcode == MUL) begin
            state_next = MUL_RUN;
          end else if (uop.opcode == LOOP) begin
            state_next = LOOP_DEC;
          end else begin
            state_next = ALU;
          end
        end
      end
      MUL_RUN:  if (last) state_next = DONE;
      LOOP_DEC: state_next = LOOP_JMP;
      ALU,
      LOOP_JMP: state_next = DONE;
      default:  state_next = IDLE;
    endcase
  end

  // ========================================
  // write strobes and source select
  // ========================================
  always_comb begin
    wr      = 1'b0;
    wrfl    = 1'b0;
    wrhi    = 1'b0;
    word_op = 1'b1;
    dsel    = `ZET_DSEL_ALU;
    unique case (state)
      ALU: begin
        wr      = 1'b1;
        // MOV leaves flags alone
        wrfl    = (cur.opcode != MOV_IMM);
        word_op = cur.word_op;
      end
      MUL_RUN: begin
        // AX, DX and flags together on the last step
        dsel = `ZET_DSEL_MUL;
        wr   = last;
        wrhi = last;
        wrfl = last;
      end
      LOOP_DEC: begin
        dsel = `ZET_DSEL_CX;
        wr   = 1'b1;
      end
      LOOP_JMP: begin
        dsel = `ZET_DSEL_IP;
        wr   = ~cx_zero_q;
      end
      default: ;
    endcase
  end

  assign busy = (state != IDLE);
  assign done = (state == DONE);

endmodule

/* rtl/zet_exec_top.sv */
// execution core top: sequencer, step timer, register file, ALU, multiplier
// and the write-data, address and flag muxes

`timescale 1ns/10ps

`include "zet_defines.svh"

module zet_exec_top import zet_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        issue,
  input  uop_t        uop,
  output logic        busy,
  output logic        done,
  input  logic [3:0]  rd_addr,
  output logic [15:0] rd_data,
  output flags_t      flags,
  output logic [15:0] cs,
  output logic [15:0] ip,
  output logic        cx_zero
);

  uop_t        cur;
  logic        mul_start;
  logic        step;
  logic        last;
  logic        wr;
  logic        wrfl;
  logic        wrhi;
  logic        word_op;
  logic [1:0]  dsel;
  logic [3:0]  addr_a;
  logic [3:0]  addr_d;
  logic [15:0] a;
  logic [15:0] b;
  logic [15:0] alu_y;
  logic [15:0] alu_res;
  logic [31:0] product;
  logic [31:0] d;
  uop_opcode_e alu_op;
  flags_t      alu_flags;
  flags_t      iflags;

  zet_exec_fsm u_fsm (
    .clk, .rst, .issue, .uop, .last, .cx_zero,
    .busy, .done, .cur, .mul_start,
    .wr, .wrfl, .wrhi, .word_op, .dsel
  );

  zet_step_timer u_timer (
    .clk, .rst, .start(mul_start), .step, .last
  );

  // ========================================
  // operand routing
  // ========================================
  // MUL reads AX, LOOP reads CX, the rest read dst
  always_comb begin
    unique case (cur.opcode)
      MUL:     addr_a = `ZET_REG_AX;
      LOOP:    addr_a = `ZET_REG_CX;
      default: addr_a = cur.dst;
    endcase
  end

  // the CX decrement rides the SUB path with y of one
  assign alu_op = (cur.opcode == LOOP) ? SUB : cur.opcode;
  assign alu_y  = (cur.opcode == LOOP) ? 16'd1 : (cur.use_imm ? cur.imm : b);

  zet_regfile u_regs (
    .clk, .rst, .a, .b, .c(rd_data), .cs, .ip, .s(), .d, .flags,
    .wr, .wrfl, .wrhi, .word_op,
    .a_byte(~word_op), .b_byte(~word_op), .c_byte(1'b0),
    .wr_ip0(1'b0), .iflags,
    .addr_a, .addr_b(cur.src), .addr_c(rd_addr), .addr_d, .addr_s(2'd0),
    .cx_zero
  );

  zet_alu u_alu (
    .op(alu_op), .x(a), .y(alu_y), .word_op, .fin(flags),
    .res(alu_res), .fout(alu_flags)
  );

  zet_mul u_mul (
    .clk, .rst, .start(mul_start), .step, .mcand(b), .mplier(a), .product
  );

  // ========================================
  // write-back muxes
  // ========================================
  always_comb begin
    iflags = alu_flags;
    unique case (dsel)
      `ZET_DSEL_MUL: begin
        addr_d = `ZET_REG_AX;
        d      = product;
        // CF and OF report a nonzero DX, all else kept
        iflags    = flags;
        iflags.cf = |product[31:16];
        iflags.of = |product[31:16];
      end
      `ZET_DSEL_CX: begin
        addr_d = `ZET_REG_CX;
        d      = {16'd0, alu_res};
      end
      `ZET_DSEL_IP: begin
        addr_d = `ZET_REG_IP;
        d      = {16'd0, ip + cur.imm};
      end
      default: begin
        addr_d = cur.dst;
        d      = {16'd0, alu_res};
      end
    endcase
  end

endmodule

/* tests/tb_zet_exec.sv */
// testbench for the execution core
// reference model, directed and random micro-ops, register compare, timeout

`timescale 1ns/10ps

`include "zet_defines.svh"

module tb_zet_exec import zet_pkg::*; ();

  // 300 micro-ops at no more than 20 cycles each
  localparam int TIMEOUT_CYCLES = 300 * 20;
  localparam int RANDOM_OPS     = 240;

  logic        clk;
  logic        rst;
  logic        issue;
  uop_t        uop;
  logic        busy;
  logic        done;
  logic [3:0]  rd_addr;
  logic [15:0] rd_data;
  flags_t      flags;
  logic [15:0] cs;
  logic [15:0] ip;
  logic        cx_zero;

  integer      seed;
  int          error_count;
  int          cycles;
  logic        check_pending;

  // model state
  logic [15:0] m_regs [16];
  flags_t      m_flags;

  zet_exec_top DUT (
    .clk, .rst, .issue, .uop, .busy, .done,
    .rd_addr, .rd_data, .flags, .cs, .ip, .cx_zero
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ========================================
  // reference model
  // ========================================
  // byte addresses 0-3 are AL..BL, 4-7 are AH..BH, reads sign extend
  function automatic logic [15:0] model_read(input logic [3:0] addr, input logic w);
    logic [7:0] half;
    if (w) begin
      return m_regs[addr];
    end
    half = addr[2] ? m_regs[{2'b00, addr[1:0]}][15:8] : m_regs[addr][7:0];
    return {{8{half[7]}}, half};
  endfunction

  function automatic void model_write(input logic [3:0] addr, input logic [15:0] v,
                                      input logic w);
    if (w) begin
      m_regs[addr] = v;
    end else if (addr[2]) begin
      m_regs[{2'b00, addr[1:0]}][15:8] = v[7:0];
    end else begin
      m_regs[addr][7:0] = v[7:0];
    end
  endfunction

  // x86 arithmetic and flag rules at 8 or 16 bits
  function automatic void alu_ref(input uop_opcode_e op, input logic [15:0] x,
                                  input logic [15:0] y, input logic w, input flags_t fin,
                                  output logic [15:0] res, output flags_t fout);
    logic [16:0] xm;
    logic [16:0] ym;
    logic [16:0] full;
    logic        sx;
    logic        sy;
    logic        sr;
    xm   = w ? {1'b0, x} : {9'd0, x[7:0]};
    ym   = w ? {1'b0, y} : {9'd0, y[7:0]};
    fout = fin;
    case (op)
      ADD:     full = xm + ym;
      SUB:     full = xm - ym;
      AND:     full = xm & ym;
      OR:      full = xm | ym;
      XOR:     full = xm ^ ym;
      default: full = ym;
    endcase
    sx = w ? x[15] : x[7];
    sy = w ? y[15] : y[7];
    sr = w ? full[15] : full[7];
    res     = full[15:0];
    fout.sf = sr;
    fout.zf = w ? (full[15:0] == 16'd0) : (full[7:0] == 8'd0);
    fout.pf = ~^full[7:0];
    fout.cf = 1'b0;
    fout.af = 1'b0;
    fout.of = 1'b0;
    if (op == ADD) begin
      fout.cf = w ? full[16] : full[8];
      fout.af = x[4] ^ y[4] ^ full[4];
      fout.of = (sx == sy) && (sr != sx);
    end else if (op == SUB) begin
      // borrow when the minuend is smaller
      fout.cf = (xm < ym);
      fout.af = x[4] ^ y[4] ^ full[4];
      fout.of = (sx != sy) && (sr != sx);
    end
  endfunction

  // apply one micro-op to the model registers and flags
  function automatic void apply_uop(input uop_t u);
    logic [15:0] x;
    logic [15:0] y;
    logic [15:0] res;
    logic [31:0] p;
    flags_t      f;
    case (u.opcode)
      MUL: begin
        p = 32'(m_regs[`ZET_REG_AX]) * 32'(m_regs[u.src]);
        m_regs[`ZET_REG_AX] = p[15:0];
        m_regs[`ZET_REG_DX] = p[31:16];
        m_flags.cf = (p[31:16] != 16'd0);
        m_flags.of = (p[31:16] != 16'd0);
      end
      LOOP: begin
        // no flag update on the count
        m_regs[`ZET_REG_CX] = m_regs[`ZET_REG_CX] - 16'd1;
        if (m_regs[`ZET_REG_CX] != 16'd0) begin
          m_regs[`ZET_REG_IP] = m_regs[`ZET_REG_IP] + u.imm;
        end
      end
      default: begin
        x = model_read(u.dst, u.word_op);
        y = u.use_imm ? u.imm : model_read(u.src, u.word_op);
        alu_ref(u.opcode, x, y, u.word_op, m_flags, res, f);
        model_write(u.dst, res, u.word_op);
        if (u.opcode != MOV_IMM) begin
          m_flags = f;
        end
      end
    endcase
  endfunction

  // cycles from the issue edge to the first cycle with done high
  function automatic int expected_latency(input uop_opcode_e op);
    if (op == MUL) begin
      return 18;
    end else if (op == LOOP) begin
      return 3;
    end
    return 2;
  endfunction

  function automatic uop_t make_uop(input uop_opcode_e op, input logic [3:0] dst,
                                    input logic [3:0] src, input logic use_imm,
                                    input logic [15:0] imm, input logic w);
    uop_t u;
    u.opcode  = op;
    u.dst     = dst;
    u.src     = src;
    u.use_imm = use_imm;
    u.imm     = imm;
    u.word_op = w;
    return u;
  endfunction

  // byte ops stay within AL..BH
  function automatic uop_t random_uop();
    logic [31:0] r1;
    logic [31:0] r2;
    uop_t        u;
    r1 = $random(seed);
    r2 = $random(seed);
    u.opcode  = uop_opcode_e'({1'b0, r1[2:0]});
    u.word_op = r1[3];
    u.dst     = r1[3] ? r1[7:4] : {1'b0, r1[6:4]};
    u.src     = r1[3] ? r1[11:8] : {1'b0, r1[10:8]};
    u.use_imm = (u.opcode == MOV_IMM) | r1[12];
    u.imm     = r2[15:0];
    return u;
  endfunction

  // ========================================
  // checking
  // ========================================
  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string what);
    if (actual !== expected) begin
      error_count++;
      $display("Error at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
      $display("*** FAILED ***");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  // walk the debug port while the core sits in DONE
  task automatic compare_state();
    for (int i = 0; i < 16; i++) begin
      rd_addr = 4'(i);
      #0.2;
      check(32'(rd_data), 32'(m_regs[i]), $sformatf("register %0d", i));
    end
    check(32'(flags), 32'(m_flags), "flags");
    check(32'(ip), 32'(m_regs[`ZET_REG_IP]), "ip");
    check(32'(cs), 32'(m_regs[`ZET_REG_CS]), "cs");
    check(32'(cx_zero), 32'(m_regs[`ZET_REG_CX] == 16'd0), "cx_zero");
  endtask

  initial begin
    forever begin
      wait (check_pending);
      compare_state();
      check_pending = 1'b0;
    end
  end

  task automatic request_compare();
    check_pending = 1'b1;
    wait (!check_pending);
  endtask

  // ========================================
  // stimulus
  // ========================================
  // stray adds an ignored MUL strobe while the core is busy
  task automatic run_uop(input uop_t u, input logic stray);
    uop_t junk;
    int   lat;
    @(negedge clk);
    check(32'(done), 32'd0, "done longer than one cycle");
    uop   = u;
    issue = 1'b1;
    @(negedge clk);
    issue = 1'b0;
    lat   = 1;
    check(32'(busy), 32'd1, "busy after issue");
    while (!done) begin
      if (stray && lat == 3) begin
        junk = make_uop(MUL, `ZET_REG_AX, 4'd5, 1'b0, 16'h5a5a, 1'b1);
        uop   = junk;
        issue = 1'b1;
      end else begin
        issue = 1'b0;
      end
      @(negedge clk);
      lat++;
    end
    issue = 1'b0;
    check(32'(lat), 32'(expected_latency(u.opcode)), "latency");
    apply_uop(u);
    request_compare();
  endtask

  initial begin
    seed          = 87892;
    error_count   = 0;
    check_pending = 1'b0;
    rst           = 1'b1;
    issue         = 1'b0;
    uop           = '0;
    rd_addr       = 4'd0;
    for (int i = 0; i < 16; i++) begin
      m_regs[i] = 16'd0;
    end
    m_regs[`ZET_REG_CS] = `ZET_CS_RESET;
    m_regs[`ZET_REG_IP] = `ZET_IP_RESET;
    m_flags             = '0;

    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // reset values
    check(32'(cs), 32'(`ZET_CS_RESET), "cs after reset");
    check(32'(ip), 32'(`ZET_IP_RESET), "ip after reset");
    check(32'(flags), 32'd0, "flags after reset");
    check(32'(busy), 32'd0, "busy after reset");
    check(32'(done), 32'd0, "done after reset");
    request_compare();

    // high byte writes keep the low halves
    run_uop(make_uop(MOV_IMM, `ZET_REG_AX, 4'd0, 1'b1, 16'h1234, 1'b1), 1'b0);
    run_uop(make_uop(MOV_IMM, 4'd4, 4'd0, 1'b1, 16'h00ab, 1'b0), 1'b0);
    run_uop(make_uop(ADD, 4'd7, 4'd0, 1'b0, 16'd0, 1'b0), 1'b0);

    // products with and without a high word
    run_uop(make_uop(MOV_IMM, `ZET_REG_AX, 4'd0, 1'b1, 16'hffff, 1'b1), 1'b0);
    run_uop(make_uop(MOV_IMM, 4'd3, 4'd0, 1'b1, 16'hffff, 1'b1), 1'b0);
    run_uop(make_uop(MUL, 4'd0, 4'd3, 1'b0, 16'd0, 1'b1), 1'b0);
    run_uop(make_uop(MOV_IMM, `ZET_REG_AX, 4'd0, 1'b1, 16'd3, 1'b1), 1'b0);
    run_uop(make_uop(MOV_IMM, 4'd3, 4'd0, 1'b1, 16'd5, 1'b1), 1'b0);
    run_uop(make_uop(MUL, 4'd0, 4'd3, 1'b0, 16'd0, 1'b1), 1'b0);

    // CX of one falls through, CX of three jumps twice
    run_uop(make_uop(MOV_IMM, `ZET_REG_CX, 4'd0, 1'b1, 16'd1, 1'b1), 1'b0);
    run_uop(make_uop(LOOP, 4'd0, 4'd0, 1'b1, 16'h0010, 1'b1), 1'b0);
    check(32'(cx_zero), 32'd1, "cx_zero after the last loop pass");
    run_uop(make_uop(MOV_IMM, `ZET_REG_CX, 4'd0, 1'b1, 16'd3, 1'b1), 1'b0);
    repeat (3) begin
      run_uop(make_uop(LOOP, 4'd0, 4'd0, 1'b1, 16'h0020, 1'b1), 1'b0);
    end

    // strobe during a multiply must be dropped
    run_uop(make_uop(MOV_IMM, `ZET_REG_AX, 4'd0, 1'b1, 16'd7, 1'b1), 1'b0);
    run_uop(make_uop(MOV_IMM, 4'd3, 4'd0, 1'b1, 16'd9, 1'b1), 1'b0);
    run_uop(make_uop(MUL, 4'd0, 4'd3, 1'b0, 16'd0, 1'b1), 1'b1);

    for (int n = 0; n < RANDOM_OPS; n++) begin
      run_uop(random_uop(), 1'b0);
    end

    @(negedge clk);
    if (error_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // cycle limit for a hung core
  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
    $display("*** FAILED ***");
    $fatal(1, "timeout");
  end

endmodule

/* build.f */
+incdir+rtl
rtl/zet_pkg.sv
rtl/zet_regfile.sv
rtl/zet_alu.sv
rtl/zet_mul.sv
rtl/zet_step_timer.sv
rtl/zet_exec_fsm.sv
rtl/zet_exec_top.sv
tests/tb_zet_exec.sv

/* run.sh */
#!/bin/sh
# build and run the execution core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f build.f --top-module tb_zet_exec \
  --Mdir obj_dir -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
  exit 1
fi
exit 0
